// ==== filelist.f ====
+incdir+verilog
verilog/video_timing_pkg.sv
verilog/bayer_pkg.sv
verilog/video_timing.sv
verilog/bar_sequencer.sv
verilog/bayer_mosaic.sv
verilog/raw_colorbar_gen.sv
sim/raw_colorbar_checker.sv
sim/tb_raw_colorbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the testbench once per bayer order (RGGB GRBG GBRG BGGR)
cd "$(dirname "$0")" || exit 1

status=0
for order in 0 1 2 3
do
	mdir=obj_dir_order$order
	log=sim_order$order.log

	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_raw_colorbar -Gbayer_order=$order \
		--Mdir $mdir -o sim_tb
	if [ $? -ne 0 ]; then
		echo "build failed for bayer order $order"
		exit 1
	fi

	./$mdir/sim_tb > $log 2>&1
	if [ $? -ne 0 ]; then
		echo "simulator exited with an error for bayer order $order"
		status=1
	fi
	cat $log

	# verdict from the log
	if grep -q "TESTBENCH FAILED" $log; then
		echo "bayer order $order failed"
		status=1
	fi
done

exit $status

// ==== sim/raw_colorbar_checker.sv ====
`timescale 1ns/1ns
`include "raw_colorbar_settings.svh"

// watches the source pins and compares them against its own raster model
module raw_colorbar_checker #(
	parameter int h_active      = 12,
	parameter int h_total       = 20,
	parameter int v_active      = 4,
	parameter int v_total       = 8,
	parameter int h_front_porch = 2,
	parameter int h_sync        = 3,
	parameter int v_front_porch = 1,
	parameter int v_sync        = 2,
	parameter int bar_width     = 2,
	parameter int bayer_order   = 0,
	parameter int word_width    = `RCB_WORD_WIDTH
) (
	input  logic                  clk,
	input  logic                  rstn_cnt,
	input  logic                  fv,
	input  logic                  lv,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic [word_width-1:0] data,
	output int                    flag_errors,
	output int                    data_errors,
	output int                    lv_runs
);
	import bayer_pkg::*;

	// counter slot 0 reaches the pins after hold-off plus three stages
	localparam int lead      = (1 << `RCB_HOLDOFF_BITS) + 3;
	localparam int frame_len = h_total * v_total;

	int   cyc = 0;       // clocks since the last reset release
	int   n_flag = 0;
	int   n_data = 0;
	int   n_runs = 0;
	logic lv_prev = 1'b0;

	assign flag_errors = n_flag;
	assign data_errors = n_data;
	assign lv_runs     = n_runs;

	// filter colour from the 2x2 tile, row major
	function automatic bar_color_e tile_color(int order, int row, int col);
		bar_color_e tile [4];
		case (order)
			0:       tile = '{RED, GREEN, GREEN, BLUE};   // RGGB
			1:       tile = '{GREEN, RED, BLUE, GREEN};   // GRBG
			2:       tile = '{GREEN, BLUE, RED, GREEN};   // GBRG
			default: tile = '{BLUE, GREEN, GREEN, RED};   // BGGR
		endcase
		return tile[(row % 2) * 2 + (col % 2)];
	endfunction

	// bar under active column k, red green blue repeating
	function automatic bar_color_e bar_of(int k);
		case ((k / bar_width) % 3)
			0:       return RED;
			1:       return GREEN;
			default: return BLUE;
		endcase
	endfunction

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp)
		begin
			$display("[ERROR] %0t %s expected %0b actual %0b", $time, name, exp, act);
			n_flag++;
		end
	endtask

	always @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// compare mid cycle, away from the drive edge
	always @(negedge clk)
	begin
		int                    n;
		int                    p;     // pixel count within line
		int                    l;     // line count within frame
		logic                  started;
		logic                  e_fv;
		logic                  e_lv;
		logic                  e_hs;
		logic                  e_vs;
		logic [word_width-1:0] e_data;
		started = rstn_cnt && (cyc >= lead);
		e_fv    = 1'b0;
		e_lv    = 1'b0;
		e_hs    = 1'b0;
		e_vs    = 1'b0;
		e_data  = '0;   // idle in reset and hold-off
		if (started)
		begin
			n    = (cyc - lead) % frame_len;
			p    = n % h_total;
			l    = n / h_total;
			e_fv = (l <= v_active + 1);
			e_lv = (p >= 1) && (p <= h_active) && (l >= 1) && (l <= v_active);
			e_hs = (p > h_active + h_front_porch) &&
			       (p <= h_active + h_front_porch + h_sync);
			e_vs = (l >= v_active + v_front_porch) &&
			       (l < v_active + v_front_porch + v_sync);
			if (e_lv && tile_color(bayer_order, l - 1, p - 1) == bar_of(p - 1))
				e_data = '1;   // site passes the bar colour
		end
		check_bit("fv", e_fv, fv);
		check_bit("lv", e_lv, lv);
		check_bit("hsync", e_hs, hsync);
		check_bit("vsync", e_vs, vsync);
		// data free between lines, fixed everywhere else
		if ((!started || e_lv) && data !== e_data)
		begin
			$display("[ERROR] %0t data expected %h actual %h", $time, e_data, data);
			n_data++;
		end
		if (lv && !lv_prev)
			n_runs++;
		lv_prev = lv;
	end

endmodule

// ==== sim/tb_raw_colorbar.sv ====
`timescale 1ns/1ns
`include "raw_colorbar_settings.svh"

// small raster with one run per bayer order
module tb_raw_colorbar #(
	parameter int bayer_order = 0
);
	localparam int h_active   = 12;
	localparam int h_total    = 20;
	localparam int v_active   = 4;
	localparam int v_total    = 8;
	localparam int h_fp       = 2;
	localparam int h_sy       = 3;
	localparam int v_fp       = 1;
	localparam int v_sy       = 2;
	localparam int bar_width  = 2;
	localparam int lead       = (1 << `RCB_HOLDOFF_BITS) + 3;
	localparam int frame_len  = h_total * v_total;
	localparam int n_rows     = 4;
	localparam int pulse_rand = -2;   // mid-frame offset drawn at run time

	// reset low length, second pulse offset after release (-1 none), frames
	typedef struct packed
	{
		int rst_len;
		int pulse_at;
		int frames;
	} scenario_t;

	scenario_t scenarios [n_rows] = '{
		'{3, -1, 2},
		'{1, pulse_rand, 1},
		'{5, 40, 1},          // pulse inside the hold-off
		'{2, pulse_rand, 2}
	};

	logic                       clk;
	logic                       rstn_cnt;
	logic                       fv;
	logic                       lv;
	logic                       hsync;
	logic                       vsync;
	logic [`RCB_WORD_WIDTH-1:0] data;
	int                         flag_errors;
	int                         data_errors;
	int                         lv_runs;
	int                         cycles = 0;
	int                         limit = 0;   // 0 until the table is sized

	raw_colorbar_gen #(
		.word_width    (`RCB_WORD_WIDTH),
		.h_active      (h_active),
		.h_total       (h_total),
		.v_active      (v_active),
		.v_total       (v_total),
		.h_front_porch (h_fp),
		.h_sync        (h_sy),
		.v_front_porch (v_fp),
		.v_sync        (v_sy),
		.bar_width     (bar_width),
		.bayer_order   (bayer_pkg::bayer_order_e'(bayer_order))
	) dut0 (
		.clk      (clk),
		.rstn_cnt (rstn_cnt),
		.fv       (fv),
		.lv       (lv),
		.hsync    (hsync),
		.vsync    (vsync),
		.data     (data)
	);

	raw_colorbar_checker #(
		.h_active      (h_active),
		.h_total       (h_total),
		.v_active      (v_active),
		.v_total       (v_total),
		.h_front_porch (h_fp),
		.h_sync        (h_sy),
		.v_front_porch (v_fp),
		.v_sync        (v_sy),
		.bar_width     (bar_width),
		.bayer_order   (bayer_order),
		.word_width    (`RCB_WORD_WIDTH)
	) chk0 (
		.clk         (clk),
		.rstn_cnt    (rstn_cnt),
		.fv          (fv),
		.lv          (lv),
		.hsync       (hsync),
		.vsync       (vsync),
		.data        (data),
		.flag_errors (flag_errors),
		.data_errors (data_errors),
		.lv_runs     (lv_runs)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;   // 40 ns period
	end

	task automatic wait_cycles(int n);
		repeat (n) @(posedge clk);
	endtask

	// low for n clocks then released on an edge
	task automatic pulse_reset(int n);
		rstn_cnt <= 1'b0;
		wait_cycles(n);
		rstn_cnt <= 1'b1;
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout after %0d cycles, the scenario table never finished", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial
	begin
		int off;
		int total;
		rstn_cnt = 1'b0;
		void'($urandom(38214));
		total    = 0;
		// worst case per row with the pulse late in the first frame
		for (int i = 0; i < n_rows; i++)
			total += scenarios[i].rst_len + lead + frame_len + 2 + lead +
			         scenarios[i].frames * frame_len;
		limit = total + 200;
		@(posedge clk);
		for (int i = 0; i < n_rows; i++)
		begin
			pulse_reset(scenarios[i].rst_len);
			off = scenarios[i].pulse_at;
			if (off == pulse_rand)
				off = lead + int'($urandom_range(frame_len - 1, 1));
			if (off >= 0)
			begin
				wait_cycles(off);
				pulse_reset(2);   // raster restarts from scratch
			end
			wait_cycles(lead + scenarios[i].frames * frame_len);
		end
		@(negedge clk);
		#1;
		if (lv_runs == 0)
			$display("no lv run was seen, the raster never started");
		$display("error counts: flags %0d, data %0d, lv runs seen %0d",
			flag_errors, data_errors, lv_runs);
		if (flag_errors == 0 && data_errors == 0 && lv_runs > 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== verilog/bar_sequencer.sv ====
`timescale 1ns/1ns
`include "raw_colorbar_settings.svh"

// second stage, tracks which bar the current pixel sits in
module bar_sequencer #(
	parameter int bar_width = `RCB_BAR_WIDTH
) (
	input  logic                          clk,
	input  logic                          rstn_cnt,
	input  video_timing_pkg::sync_flags_t timing_flags,
	input  video_timing_pkg::raster_cnt_t col,
	input  logic                          row_odd,
	output video_timing_pkg::sync_flags_t bar_flags,
	output bayer_pkg::bar_color_e         bar_color,
	output logic                          bar_row_odd,
	output logic                          bar_col_odd
);
	import video_timing_pkg::*;
	import bayer_pkg::*;

	localparam raster_cnt_t bar_last = raster_cnt_t'(bar_width - 1);

	raster_cnt_t bar_cnt;    // position inside the bar of the incoming pixel
	bar_color_e  cur_color;  // colour of the incoming pixel
	bar_color_e  next_color;

	// red -> green -> blue -> red
	always_comb
	begin
		case (cur_color)
			RED:     next_color = GREEN;
			GREEN:   next_color = BLUE;
			default: next_color = RED;
		endcase
	end

	// restart on every line gap
	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
		begin
			bar_cnt   <= '0;
			cur_color <= RED;
		end
		else if (!timing_flags.lv)
		begin
			bar_cnt   <= '0;
			cur_color <= RED;
		end
		else if (bar_cnt == bar_last)
		begin
			bar_cnt   <= '0;
			cur_color <= next_color;  // bar boundary
		end
		else
			bar_cnt <= bar_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
			bar_flags <= '0;
		else
			bar_flags <= timing_flags;
	end

	// payload, qualified by bar_flags.lv downstream
	always_ff @(posedge clk)
	begin
		bar_color   <= cur_color;
		bar_row_odd <= row_odd;
		bar_col_odd <= col[0];
	end

	a_bar_cnt_range: assert property (@(posedge clk) disable iff (!rstn_cnt)
		bar_cnt <= bar_last);

	// first active column always starts a fresh red bar
	a_line_start: assert property (@(posedge clk) disable iff (!rstn_cnt)
		timing_flags.lv && col == '0 |-> bar_cnt == '0 && cur_color == RED);

endmodule

// ==== verilog/bayer_mosaic.sv ====
`timescale 1ns/1ns
`include "raw_colorbar_settings.svh"

// last stage sampling the bar colour through the colour filter
module bayer_mosaic #(
	parameter bayer_pkg::bayer_order_e bayer_order = bayer_pkg::BGGR,
	parameter int                      word_width  = `RCB_WORD_WIDTH
) (
	input  logic                          clk,
	input  logic                          rstn_cnt,
	input  video_timing_pkg::sync_flags_t bar_flags,
	input  bayer_pkg::bar_color_e         bar_color,
	input  logic                          bar_row_odd,
	input  logic                          bar_col_odd,
	output logic                          fv,
	output logic                          lv,
	output logic                          hsync,
	output logic                          vsync,
	output logic [word_width-1:0]         data
);
	import bayer_pkg::*;

	bar_color_e site;  // filter colour over this pixel
	logic       hit;   // site passes the bar colour

	always_comb
	begin
		site = site_color(bayer_order, bar_row_odd, bar_col_odd);
		hit  = bar_flags.lv && (site == bar_color);  // blank outside lv
	end

	// flags split out to the top pins
	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
		begin
			fv    <= 1'b0;
			lv    <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			fv    <= bar_flags.fv;
			lv    <= bar_flags.lv;
			hsync <= bar_flags.hsync;
			vsync <= bar_flags.vsync;
		end
	end

	// full scale on a match, black otherwise
	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
			data <= '0;
		else if (hit)
			data <= {word_width{1'b1}};
		else
			data <= '0;
	end

	// pure bars without grey levels
	a_data_levels: assert property (@(posedge clk) disable iff (!rstn_cnt)
		data == '0 || data == {word_width{1'b1}});

endmodule

// ==== verilog/bayer_pkg.sv ====
package bayer_pkg;

	// colour filter order of the sensor, named by the top left 2x2 tile
	typedef enum logic [1:0]
	{
		RGGB = 2'd0,
		GRBG = 2'd1,
		GBRG = 2'd2,
		BGGR = 2'd3
	} bayer_order_e;

	// bar colours, also the colour of one filter site
	typedef enum logic [1:0]
	{
		RED   = 2'd0,
		GREEN = 2'd1,
		BLUE  = 2'd2
	} bar_color_e;

	// colour seen by the site at (row parity, column parity)
	function automatic bar_color_e site_color(bayer_order_e order, logic row_odd,
		logic col_odd);
		logic diag;    // site on the even/even or odd/odd diagonal
		diag = (row_odd == col_odd);
		case (order)
			RGGB:    return diag ? (row_odd ? BLUE : RED) : GREEN;
			BGGR:    return diag ? (row_odd ? RED : BLUE) : GREEN;
			GRBG:    return diag ? GREEN : (row_odd ? BLUE : RED);
			GBRG:    return diag ? GREEN : (row_odd ? RED : BLUE);
			default: return GREEN;
		endcase
	endfunction

endpackage

// ==== verilog/raw_colorbar_gen.sv ====
`timescale 1ns/1ns
`include "raw_colorbar_settings.svh"

// raw bayer colour bar source
// video_timing -> bar_sequencer -> bayer_mosaic, one clock each
module raw_colorbar_gen #(
	parameter int                      word_width    = `RCB_WORD_WIDTH,
	parameter int                      h_active      = `RCB_H_ACTIVE,
	parameter int                      h_total       = `RCB_H_TOTAL,
	parameter int                      v_active      = `RCB_V_ACTIVE,
	parameter int                      v_total       = `RCB_V_TOTAL,
	parameter int                      h_front_porch = `RCB_H_FRONT_PORCH,
	parameter int                      h_sync        = `RCB_H_SYNC,
	parameter int                      v_front_porch = `RCB_V_FRONT_PORCH,
	parameter int                      v_sync        = `RCB_V_SYNC,
	parameter int                      bar_width     = `RCB_BAR_WIDTH,
	parameter bayer_pkg::bayer_order_e bayer_order   = bayer_pkg::BGGR
) (
	input  logic                  clk,
	input  logic                  rstn_cnt,  // async, low active
	output logic                  fv,
	output logic                  lv,
	output logic                  hsync,
	output logic                  vsync,
	output logic [word_width-1:0] data
);
	import video_timing_pkg::*;
	import bayer_pkg::*;

	// stage 1 outputs
	sync_flags_t timing_flags;
	raster_cnt_t col;
	logic        row_odd;

	// stage 2 outputs
	sync_flags_t bar_flags;
	bar_color_e  bar_color;
	logic        bar_row_odd;
	logic        bar_col_odd;

	video_timing #(
		.h_active      (h_active),
		.h_total       (h_total),
		.v_active      (v_active),
		.v_total       (v_total),
		.h_front_porch (h_front_porch),
		.h_sync        (h_sync),
		.v_front_porch (v_front_porch),
		.v_sync        (v_sync)
	) u_video_timing (
		.clk          (clk),
		.rstn_cnt     (rstn_cnt),
		.timing_flags (timing_flags),
		.col          (col),
		.row_odd      (row_odd)
	);

	bar_sequencer #(
		.bar_width (bar_width)
	) u_bar_sequencer (
		.clk          (clk),
		.rstn_cnt     (rstn_cnt),
		.timing_flags (timing_flags),
		.col          (col),
		.row_odd      (row_odd),
		.bar_flags    (bar_flags),
		.bar_color    (bar_color),
		.bar_row_odd  (bar_row_odd),
		.bar_col_odd  (bar_col_odd)
	);

	bayer_mosaic #(
		.bayer_order (bayer_order),
		.word_width  (word_width)
	) u_bayer_mosaic (
		.clk         (clk),
		.rstn_cnt    (rstn_cnt),
		.bar_flags   (bar_flags),
		.bar_color   (bar_color),
		.bar_row_odd (bar_row_odd),
		.bar_col_odd (bar_col_odd),
		.fv          (fv),
		.lv          (lv),
		.hsync       (hsync),
		.vsync       (vsync),
		.data        (data)
	);

endmodule

// ==== verilog/raw_colorbar_settings.svh ====
`ifndef RAW_COLORBAR_SETTINGS_SVH
`define RAW_COLORBAR_SETTINGS_SVH

// raw pixel word, 10 bit sensor style
`define RCB_WORD_WIDTH 10

// raster counters, wide enough for 2200 x 1125
`define RCB_CNT_WIDTH 12

// 1080p raster sizes in clocks and lines
`define RCB_H_ACTIVE 1920
`define RCB_H_TOTAL 2200
`define RCB_V_ACTIVE 1080
`define RCB_V_TOTAL 1125

// horizontal blanking placement
`define RCB_H_FRONT_PORCH 88
`define RCB_H_SYNC 44

// vertical blanking placement, in lines
`define RCB_V_FRONT_PORCH 4
`define RCB_V_SYNC 5

// pixels per colour bar
`define RCB_BAR_WIDTH 160

// hold-off after reset release is 2**7 = 128 clocks
`define RCB_HOLDOFF_BITS 7

`endif

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ns
`include "raw_colorbar_settings.svh"

// raster generator, first pipeline stage
module video_timing #(
	parameter int h_active      = `RCB_H_ACTIVE,
	parameter int h_total       = `RCB_H_TOTAL,
	parameter int v_active      = `RCB_V_ACTIVE,
	parameter int v_total       = `RCB_V_TOTAL,
	parameter int h_front_porch = `RCB_H_FRONT_PORCH,
	parameter int h_sync        = `RCB_H_SYNC,
	parameter int v_front_porch = `RCB_V_FRONT_PORCH,
	parameter int v_sync        = `RCB_V_SYNC
) (
	input  logic                          clk,
	input  logic                          rstn_cnt,
	output video_timing_pkg::sync_flags_t timing_flags,
	output video_timing_pkg::raster_cnt_t col,     // active column, from 0
	output logic                          row_odd  // active line parity
);
	import video_timing_pkg::*;

	localparam int holdoff_bits = `RCB_HOLDOFF_BITS;

	// raster limits in counter width
	localparam raster_cnt_t h_last   = raster_cnt_t'(h_total - 1);
	localparam raster_cnt_t v_last   = raster_cnt_t'(v_total - 1);
	localparam raster_cnt_t h_act    = raster_cnt_t'(h_active);
	localparam raster_cnt_t v_act    = raster_cnt_t'(v_active);
	localparam raster_cnt_t fv_last  = raster_cnt_t'(v_active + 1);  // fv spans 0..v_active+1
	localparam raster_cnt_t hs_start = raster_cnt_t'(h_active + h_front_porch);
	localparam raster_cnt_t hs_end   = raster_cnt_t'(h_active + h_front_porch + h_sync);
	localparam raster_cnt_t vs_start = raster_cnt_t'(v_active + v_front_porch);
	localparam raster_cnt_t vs_end   = raster_cnt_t'(v_active + v_front_porch + v_sync);

	logic [holdoff_bits:0] holdoff_cnt;  // top bit set once 128 clocks have passed
	logic                  run;
	raster_cnt_t           pix_cnt;      // p, clock within line
	raster_cnt_t           line_cnt;     // l, line within frame
	sync_flags_t           raster_flags; // flags decoded from (p, l)

	assign run = holdoff_cnt[holdoff_bits];

	// hold-off after reset release, saturates on the top bit
	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
			holdoff_cnt <= '0;
		else if (!run)
			holdoff_cnt <= holdoff_cnt + 1'b1;
	end

	// pixel and line counters, parked at 0 during hold-off
	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
		begin
			pix_cnt  <= '0;
			line_cnt <= '0;
		end
		else if (run)
		begin
			if (pix_cnt == h_last)
			begin
				pix_cnt  <= '0;
				line_cnt <= (line_cnt == v_last) ? '0 : line_cnt + 1'b1;  // frame wrap
			end
			else
				pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// raster decode
	always_comb
	begin
		raster_flags.fv    = (line_cnt <= fv_last);
		raster_flags.lv    = (pix_cnt != '0) && (pix_cnt <= h_act) &&
		                     (line_cnt != '0) && (line_cnt <= v_act);
		raster_flags.hsync = (pix_cnt > hs_start) && (pix_cnt <= hs_end);
		raster_flags.vsync = (line_cnt >= vs_start) && (line_cnt < vs_end);
	end

	// registered flags, held idle until the hold-off ends
	always_ff @(posedge clk or negedge rstn_cnt)
	begin
		if (!rstn_cnt)
			timing_flags <= '0;
		else
			timing_flags <= run ? raster_flags : '0;
	end

	// active position, meaningful only while lv
	always_ff @(posedge clk)
	begin
		col     <= pix_cnt - 1'b1;  // p = 1 is column 0
		row_odd <= ~line_cnt[0];    // l = 1 is row 0, even
	end

	// lv never leaves the frame
	a_lv_in_fv: assert property (@(posedge clk) disable iff (!rstn_cnt)
		timing_flags.lv |-> timing_flags.fv);

	// column stays inside the active width
	a_col_range: assert property (@(posedge clk) disable iff (!rstn_cnt)
		timing_flags.lv |-> col < h_act);

endmodule

// ==== verilog/video_timing_pkg.sv ====
`include "raw_colorbar_settings.svh"

package video_timing_pkg;

	// pixel and line counter word
	typedef logic [`RCB_CNT_WIDTH-1:0] raster_cnt_t;

	// sync flags of one pixel slot
	// travel down the pipeline next to the pixel they belong to
	typedef struct packed
	{
		logic fv;    // frame valid
		logic lv;    // line valid
		logic hsync;
		logic vsync;
	} sync_flags_t;

endpackage
